//--- all.f
design/afu_chk_pkg.sv
design/tlp_field_capture.sv
design/tx_req_checker.sv
design/mmio_rsp_tracker.sv
design/err_vector_logger.sv
design/afu_protocol_chk.sv
verification/afu_protocol_chk_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module afu_protocol_chk_tb \
   -o afu_chk_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/afu_chk_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx '>>> PASS' && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- verification/afu_protocol_chk_tb.sv
`timescale 1ns/1ps

module afu_protocol_chk_tb;

   localparam int          CLK_PERIOD   = 100;
   localparam int          RST_CYCLES   = 8;
   localparam int          MMIO_TIMEOUT = 64;
   localparam int          NUM_TESTS    = 5;
   localparam int          WATCHDOG_CYC = NUM_TESTS * 200 + 400;   // Plus margin
   localparam int          BEAT_WAIT    = 50;
   localparam logic [31:0] SEED         = 32'd77;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  i_rx_valid;
   afu_chk_pkg::data_t    i_rx_data;
   logic                  i_rx_last;
   logic                  o_rx_ready;
   logic                  o_rx_valid;
   afu_chk_pkg::data_t    o_rx_data;
   logic                  o_rx_last;
   logic                  i_rx_ready;
   logic                  i_tx_valid;
   afu_chk_pkg::data_t    i_tx_data;
   logic                  i_tx_last;
   logic                  o_tx_ready;
   logic                  i_host_tx_ready;
   logic                  o_host_tx_valid;
   afu_chk_pkg::data_t    o_host_tx_data;
   logic                  o_host_tx_last;
   logic                  i_clear_errors;
   afu_chk_pkg::err_vec_t o_err_vector;
   afu_chk_pkg::hdr_t     o_err_hdr;
   logic                  o_blocking;

   int                    err_cnt = 0;
   int                    test_err_base;
   int                    tests_run = 0;
   int                    tests_failed = 0;
   string                 cur_test;
   logic [31:0]           rand_state;
   logic [31:0]           bp_state;
   int                    host_ready_mode;   // 0 ready, 1 random stalls, 2 held low
   logic                  host_quiet;        // Host side must see no valid
   int                    leak_cnt;
   afu_chk_pkg::data_t    exp_q[$];          // Beats the AFU side got accepted
   logic                  exp_last_q[$];
   afu_chk_pkg::data_t    got_q[$];          // Beats seen on the host side
   logic                  got_last_q[$];

   afu_protocol_chk #(
      .MAX_PLD_SIZE    (512),
      .MAX_RD_REQ_SIZE (512),
      .MAX_TAGS        (96),
      .MMIO_DEPTH      (4),
      .MMIO_TIMEOUT    (MMIO_TIMEOUT)
   ) dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .i_rx_valid      (i_rx_valid),
      .i_rx_data       (i_rx_data),
      .i_rx_last       (i_rx_last),
      .o_rx_ready      (o_rx_ready),
      .o_rx_valid      (o_rx_valid),
      .o_rx_data       (o_rx_data),
      .o_rx_last       (o_rx_last),
      .i_rx_ready      (i_rx_ready),
      .i_tx_valid      (i_tx_valid),
      .i_tx_data       (i_tx_data),
      .i_tx_last       (i_tx_last),
      .o_tx_ready      (o_tx_ready),
      .i_host_tx_ready (i_host_tx_ready),
      .o_host_tx_valid (o_host_tx_valid),
      .o_host_tx_data  (o_host_tx_data),
      .o_host_tx_last  (o_host_tx_last),
      .i_clear_errors  (i_clear_errors),
      .o_err_vector    (o_err_vector),
      .o_err_hdr       (o_err_hdr),
      .o_blocking      (o_blocking)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ##############################
   // Random data and header build
   // ##############################
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_word();
      rand_state = xorshift32(rand_state);
      return rand_state;
   endfunction

   function automatic afu_chk_pkg::data_t rand_beat();
      afu_chk_pkg::data_t b;
      b = {rand_word(), rand_word(), rand_word(), rand_word()};
      return b;
   endfunction

   function automatic afu_chk_pkg::hdr_t make_hdr(input afu_chk_pkg::fmt_t fmt,
                                                  input int len_dw,
                                                  input afu_chk_pkg::tag_t tag);
      afu_chk_pkg::hdr_t h;
      h        = '0;
      h[7:0]   = fmt;
      h[17:8]  = 10'(len_dw);   // 1024 wraps to 0
      h[31:24] = tag;
      h[63:32] = rand_word();   // Address bits, not checked
      return h;
   endfunction

   // Host side ready, changed just after the edge
   always @(posedge clk) begin
      #1;
      bp_state = xorshift32(bp_state);
      case (host_ready_mode)
         0:       i_host_tx_ready = 1'b1;
         1:       i_host_tx_ready = bp_state[0];
         default: i_host_tx_ready = 1'b0;
      endcase
   end

   // Host side monitor, inputs settled by the falling edge
   always @(negedge clk) begin
      if (rst_n && o_host_tx_valid && i_host_tx_ready) begin
         got_q.push_back(o_host_tx_data);
         got_last_q.push_back(o_host_tx_last);
      end
      if (host_quiet && o_host_tx_valid) leak_cnt++;
   end

   // ##############################
   // Compare tasks
   // ##############################
   task automatic compare_err(input string what, input afu_chk_pkg::err_vec_t exp,
                              input afu_chk_pkg::err_vec_t act);
      if (act !== exp) begin
         $display("[FAIL] %s, %s: expected %h actual %h", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic compare_hdr(input string what, input afu_chk_pkg::hdr_t exp,
                              input afu_chk_pkg::hdr_t act);
      if (act !== exp) begin
         $display("[FAIL] %s, %s: expected %h actual %h", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic compare_data(input string what, input afu_chk_pkg::data_t exp,
                               input afu_chk_pkg::data_t act);
      if (act !== exp) begin
         $display("[FAIL] %s, %s: expected %h actual %h", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic compare_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s, %s: expected %b actual %b", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   // ##############################
   // Drive tasks
   // ##############################
   task automatic drive_tx_beat(input afu_chk_pkg::data_t d, input logic last);
      int waited;
      waited     = 0;
      i_tx_valid = 1'b1;
      i_tx_data  = d;
      i_tx_last  = last;
      @(negedge clk);
      while (!o_tx_ready && waited < BEAT_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (o_tx_ready) begin
         exp_q.push_back(d);   // Moves on the coming edge
         exp_last_q.push_back(last);
      end else begin
         $display("%s: TX beat not accepted within %0d cycles", cur_test, BEAT_WAIT);
         err_cnt++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic send_tx(input afu_chk_pkg::hdr_t hdr, input int beats);
      int i;
      drive_tx_beat({rand_word(), rand_word(), hdr}, beats == 0);
      for (i = 0; i < beats; i++) begin
         drive_tx_beat(rand_beat(), i == beats - 1);
      end
      i_tx_valid = 1'b0;
      i_tx_last  = 1'b0;
      repeat (5) @(posedge clk);
      #1;
   endtask

   task automatic drive_rx_beat(input afu_chk_pkg::data_t d, input logic last,
                                input int stall);
      int n;
      i_rx_valid = 1'b1;
      i_rx_data  = d;
      i_rx_last  = last;
      for (n = 0; n < stall; n++) begin
         i_rx_ready = 1'b0;   // AFU holds the beat off
         @(negedge clk);
         compare_bit("rx ready while AFU stalls", 1'b0, o_rx_ready);
         @(posedge clk);
         #1;
      end
      i_rx_ready = 1'b1;
      @(negedge clk);
      compare_bit("rx ready to host", 1'b1, o_rx_ready);
      compare_bit("rx valid to AFU", 1'b1, o_rx_valid);
      compare_data("rx data to AFU", d, o_rx_data);
      compare_bit("rx last to AFU", last, o_rx_last);
      @(posedge clk);
      #1;
   endtask

   task automatic send_rx(input afu_chk_pkg::hdr_t hdr, input int beats, input int stall);
      int i;
      drive_rx_beat({rand_word(), rand_word(), hdr}, beats == 0, stall);
      for (i = 0; i < beats; i++) begin
         drive_rx_beat(rand_beat(), i == beats - 1, 0);
      end
      i_rx_valid = 1'b0;
      i_rx_last  = 1'b0;
      repeat (5) @(posedge clk);
      #1;
   endtask

   task automatic clear_errors();
      i_clear_errors = 1'b1;
      @(posedge clk);
      #1;
      i_clear_errors = 1'b0;
      compare_err("vector after clear", '0, o_err_vector);
      compare_bit("blocking after clear", 1'b0, o_blocking);
   endtask

   task automatic check_host_beats();
      int n;
      if (got_q.size() != exp_q.size()) begin
         $display("%s: host received %0d beats but %0d were sent", cur_test,
                  got_q.size(), exp_q.size());
         err_cnt++;
      end else begin
         for (n = 0; n < exp_q.size(); n++) begin
            compare_data("host beat", exp_q[n], got_q[n]);
            compare_bit("host last", exp_last_q[n], got_last_q[n]);
         end
      end
   endtask

   task automatic begin_test(input string name);
      cur_test      = name;
      test_err_base = err_cnt;
      exp_q.delete();
      exp_last_q.delete();
      got_q.delete();
      got_last_q.delete();
      leak_cnt      = 0;
      clear_errors();
   endtask

   task automatic end_test();
      tests_run++;
      if (err_cnt == test_err_base) begin
         $display("[done] %s ok", cur_test);
      end else begin
         tests_failed++;
         $display("[done] %s failed with %0d errors", cur_test, err_cnt - test_err_base);
      end
   endtask

   // One offending packet, one error bit and the captured header
   task automatic expect_single_err(input string what, input afu_chk_pkg::hdr_t hdr,
                                    input int beats, input int bit_idx);
      afu_chk_pkg::err_vec_t exp;
      exp          = '0;
      exp[bit_idx] = 1'b1;
      clear_errors();
      send_tx(hdr, beats);
      compare_err(what, exp, o_err_vector);
      compare_hdr({what, " header"}, hdr, o_err_hdr);
      compare_bit({what, " blocking"}, 1'b1, o_blocking);
   endtask

   // ##############################
   // Tests
   // ##############################
   task automatic test_legal_traffic();
      begin_test("legal_traffic");
      host_ready_mode = 1;   // Random host stalls
      send_tx(make_hdr(afu_chk_pkg::FMT_MWR, 16, 8'h12), 4);
      send_tx(make_hdr(afu_chk_pkg::FMT_MWR, 128, 8'h00), 32);   // 512 bytes, the limit
      send_tx(make_hdr(afu_chk_pkg::FMT_MWR, 1, 8'h00), 1);
      send_tx(make_hdr(afu_chk_pkg::FMT_MRD, 128, 8'd95), 0);
      send_rx(make_hdr(afu_chk_pkg::FMT_MRD, 1, 8'd7), 0, 3);   // AFU stalls the read
      send_tx(make_hdr(afu_chk_pkg::FMT_CPLD, 1, 8'd7), 1);
      host_ready_mode = 0;
      check_host_beats();
      compare_err("vector", '0, o_err_vector);
      compare_bit("blocking", 1'b0, o_blocking);
      end_test();
   endtask

   task automatic test_header_rules();
      begin_test("header_rules");
      expect_single_err("write 640 bytes", make_hdr(afu_chk_pkg::FMT_MWR, 160, 8'd1), 40,
                        afu_chk_pkg::ERR_MAX_PLD);
      expect_single_err("read 1024 bytes", make_hdr(afu_chk_pkg::FMT_MRD, 256, 8'd2), 0,
                        afu_chk_pkg::ERR_MAX_RD_REQ);
      expect_single_err("read tag 100", make_hdr(afu_chk_pkg::FMT_MRD, 1, 8'd100), 0,
                        afu_chk_pkg::ERR_MAX_TAG);
      expect_single_err("type 0x33", make_hdr(8'h33, 1, 8'd3), 0,
                        afu_chk_pkg::ERR_MALFORMED);
      end_test();
   endtask

   task automatic test_payload_rules();
      begin_test("payload_rules");
      expect_single_err("8 dw in one beat", make_hdr(afu_chk_pkg::FMT_MWR, 8, 8'd4), 1,
                        afu_chk_pkg::ERR_WR_INSUFF);
      expect_single_err("8 dw in three beats", make_hdr(afu_chk_pkg::FMT_MWR, 8, 8'd5), 3,
                        afu_chk_pkg::ERR_WR_OVERRUN);
      end_test();
   endtask

   task automatic test_mmio_completions();
      afu_chk_pkg::hdr_t     cpl_hdr;
      afu_chk_pkg::err_vec_t exp;
      begin_test("mmio_completions");
      exp                            = '0;
      exp[afu_chk_pkg::ERR_UNEXP_RSP] = 1'b1;
      cpl_hdr = make_hdr(afu_chk_pkg::FMT_CPLD, 1, 8'd10);
      send_rx(make_hdr(afu_chk_pkg::FMT_MRD, 1, 8'd9), 0, 0);
      send_tx(cpl_hdr, 1);
      compare_err("wrong tag", exp, o_err_vector);
      compare_hdr("wrong tag header", cpl_hdr, o_err_hdr);
      clear_errors();
      send_tx(make_hdr(afu_chk_pkg::FMT_CPLD, 1, 8'd9), 1);   // Drains the read
      compare_err("matching after wrong tag", '0, o_err_vector);
      expect_single_err("none outstanding", make_hdr(afu_chk_pkg::FMT_CPLD, 1, 8'd1), 1,
                        afu_chk_pkg::ERR_UNEXP_RSP);
      // Unanswered read
      clear_errors();
      exp                                = '0;
      exp[afu_chk_pkg::ERR_MMIO_TIMEOUT] = 1'b1;
      send_rx(make_hdr(afu_chk_pkg::FMT_MRD, 1, 8'd11), 0, 0);
      repeat (MMIO_TIMEOUT - 24) @(posedge clk);
      #1;
      compare_err("before timeout", '0, o_err_vector);
      repeat (100 - MMIO_TIMEOUT + 24) @(posedge clk);
      #1;
      compare_err("timeout", exp, o_err_vector);
      end_test();
   endtask

   task automatic test_blocking();
      afu_chk_pkg::hdr_t     bad_hdr;
      afu_chk_pkg::err_vec_t exp;
      begin_test("blocking");
      exp                             = '0;
      exp[afu_chk_pkg::ERR_MALFORMED] = 1'b1;
      bad_hdr = make_hdr(8'h33, 1, 8'd6);
      send_tx(bad_hdr, 0);
      compare_bit("blocking", 1'b1, o_blocking);
      leak_cnt        = 0;
      host_quiet      = 1'b1;
      host_ready_mode = 2;   // Only the blocking path can accept now
      send_tx(make_hdr(afu_chk_pkg::FMT_MWR, 8, 8'd7), 2);
      host_quiet      = 1'b0;
      if (leak_cnt != 0) begin
         $display("%s: host side saw valid beats while blocking", cur_test);
         err_cnt++;
      end
      compare_err("vector while blocked", exp, o_err_vector);
      compare_hdr("first header kept", bad_hdr, o_err_hdr);
      host_ready_mode = 0;
      clear_errors();
      exp_q.delete();
      exp_last_q.delete();
      got_q.delete();
      got_last_q.delete();
      send_tx(make_hdr(afu_chk_pkg::FMT_MWR, 8, 8'd8), 2);
      check_host_beats();
      compare_err("vector after clear", '0, o_err_vector);
      end_test();
   endtask

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rand_state      = SEED;
      bp_state        = xorshift32(SEED);
      host_ready_mode = 0;
      host_quiet      = 1'b0;
      rst_n           = 1'b0;
      i_rx_valid      = 1'b0;
      i_rx_data       = '0;
      i_rx_last       = 1'b0;
      i_rx_ready      = 1'b1;   // AFU takes RX beats unless a test stalls it
      i_tx_valid      = 1'b0;
      i_tx_data       = '0;
      i_tx_last       = 1'b0;
      i_host_tx_ready = 1'b1;
      i_clear_errors  = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      test_legal_traffic();
      test_header_rules();
      test_payload_rules();
      test_mmio_completions();
      test_blocking();
      $display("Tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
               err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- design/afu_protocol_chk.sv
`timescale 1ns/1ps

module afu_protocol_chk #(
   parameter int MAX_PLD_SIZE    = 512,
   parameter int MAX_RD_REQ_SIZE = 512,
   parameter int MAX_TAGS        = 96,
   parameter int MMIO_DEPTH      = 4,
   parameter int MMIO_TIMEOUT    = 64
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // Host to AFU
   input  logic                  i_rx_valid,
   input  afu_chk_pkg::data_t    i_rx_data,
   input  logic                  i_rx_last,
   output logic                  o_rx_ready,
   output logic                  o_rx_valid,
   output afu_chk_pkg::data_t    o_rx_data,
   output logic                  o_rx_last,
   input  logic                  i_rx_ready,
   // AFU to host
   input  logic                  i_tx_valid,
   input  afu_chk_pkg::data_t    i_tx_data,
   input  logic                  i_tx_last,
   output logic                  o_tx_ready,
   input  logic                  i_host_tx_ready,
   output logic                  o_host_tx_valid,
   output afu_chk_pkg::data_t    o_host_tx_data,
   output logic                  o_host_tx_last,
   // Error reporting
   input  logic                  i_clear_errors,
   output afu_chk_pkg::err_vec_t o_err_vector,
   output afu_chk_pkg::hdr_t     o_err_hdr,
   output logic                  o_blocking
);

   logic                  rx_hdr_vld;
   afu_chk_pkg::fmt_t     rx_fmt;
   afu_chk_pkg::tag_t     rx_tag;
   logic                  tx_hdr_vld;
   afu_chk_pkg::fmt_t     tx_fmt;
   afu_chk_pkg::len_dw_t  tx_len;
   afu_chk_pkg::tag_t     tx_tag;
   afu_chk_pkg::hdr_t     tx_hdr;
   logic                  tx_beat_vld;
   logic                  tx_eop;
   logic                  tx_ready;    // AFU side ready, also seen by the capture
   afu_chk_pkg::err_vec_t chk_err;
   afu_chk_pkg::err_vec_t mmio_err;

   // RX passes straight through
   assign o_rx_valid = i_rx_valid;
   assign o_rx_data  = i_rx_data;
   assign o_rx_last  = i_rx_last;
   assign o_rx_ready = i_rx_ready;
   assign o_tx_ready = tx_ready;

   tlp_field_capture u_capture (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_rx_valid    (i_rx_valid),
      .i_rx_ready    (i_rx_ready),
      .i_rx_data     (i_rx_data),
      .i_rx_last     (i_rx_last),
      .i_tx_valid    (i_tx_valid),
      .i_tx_ready    (tx_ready),
      .i_tx_data     (i_tx_data),
      .i_tx_last     (i_tx_last),
      .o_rx_hdr_vld  (rx_hdr_vld),
      .o_rx_fmt      (rx_fmt),
      .o_rx_tag      (rx_tag),
      .o_tx_hdr_vld  (tx_hdr_vld),
      .o_tx_fmt      (tx_fmt),
      .o_tx_len      (tx_len),
      .o_tx_tag      (tx_tag),
      .o_tx_hdr      (tx_hdr),
      .o_tx_beat_vld (tx_beat_vld),
      .o_tx_eop      (tx_eop)
   );

   tx_req_checker #(
      .MAX_PLD_SIZE    (MAX_PLD_SIZE),
      .MAX_RD_REQ_SIZE (MAX_RD_REQ_SIZE),
      .MAX_TAGS        (MAX_TAGS)
   ) u_req_chk (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_tx_hdr_vld  (tx_hdr_vld),
      .i_tx_fmt      (tx_fmt),
      .i_tx_len      (tx_len),
      .i_tx_tag      (tx_tag),
      .i_tx_beat_vld (tx_beat_vld),
      .i_tx_eop      (tx_eop),
      .o_err         (chk_err)
   );

   mmio_rsp_tracker #(
      .MMIO_DEPTH   (MMIO_DEPTH),
      .MMIO_TIMEOUT (MMIO_TIMEOUT)
   ) u_mmio_trk (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_rx_hdr_vld (rx_hdr_vld),
      .i_rx_fmt     (rx_fmt),
      .i_rx_tag     (rx_tag),
      .i_tx_hdr_vld (tx_hdr_vld),
      .i_tx_fmt     (tx_fmt),
      .i_tx_tag     (tx_tag),
      .o_err        (mmio_err)
   );

   err_vector_logger u_err_log (
      .clk             (clk),
      .rst_n           (rst_n),
      .i_clear_errors  (i_clear_errors),
      .i_chk_err       (chk_err),
      .i_mmio_err      (mmio_err),
      .i_tx_hdr_vld    (tx_hdr_vld),
      .i_tx_hdr        (tx_hdr),
      .i_tx_valid      (i_tx_valid),
      .i_tx_data       (i_tx_data),
      .i_tx_last       (i_tx_last),
      .i_host_tx_ready (i_host_tx_ready),
      .o_tx_ready      (tx_ready),
      .o_host_tx_valid (o_host_tx_valid),
      .o_host_tx_data  (o_host_tx_data),
      .o_host_tx_last  (o_host_tx_last),
      .o_err_vector    (o_err_vector),
      .o_err_hdr       (o_err_hdr),
      .o_blocking      (o_blocking)
   );

endmodule

//--- design/err_vector_logger.sv
`timescale 1ns/1ps

module err_vector_logger (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  i_clear_errors,
   input  afu_chk_pkg::err_vec_t i_chk_err,
   input  afu_chk_pkg::err_vec_t i_mmio_err,
   input  logic                  i_tx_hdr_vld,
   input  afu_chk_pkg::hdr_t     i_tx_hdr,
   input  logic                  i_tx_valid,
   input  afu_chk_pkg::data_t    i_tx_data,
   input  logic                  i_tx_last,
   input  logic                  i_host_tx_ready,
   output logic                  o_tx_ready,
   output logic                  o_host_tx_valid,
   output afu_chk_pkg::data_t    o_host_tx_data,
   output logic                  o_host_tx_last,
   output afu_chk_pkg::err_vec_t o_err_vector,
   output afu_chk_pkg::hdr_t     o_err_hdr,
   output logic                  o_blocking
);

   afu_chk_pkg::err_vec_t err_in;
   afu_chk_pkg::hdr_t     last_hdr;   // Header of the packet in flight

   assign err_in = i_chk_err | i_mmio_err;

   always_ff @(posedge clk) begin
      if (i_tx_hdr_vld) last_hdr <= i_tx_hdr;
   end

   // ##############################
   // Sticky errors and first header
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_err_vector <= '0;
         o_err_hdr    <= '0;
         o_blocking   <= 1'b0;
      end else if (i_clear_errors) begin
         o_err_vector <= '0;
         o_err_hdr    <= '0;
         o_blocking   <= 1'b0;
      end else begin
         o_err_vector <= o_err_vector | err_in;
         if (|err_in) begin
            o_blocking <= 1'b1;
            if (!o_blocking) o_err_hdr <= last_hdr;   // Only the first one
         end
      end
   end

   // TX path, AFU beats are swallowed while blocking
   always_comb begin
      o_tx_ready      = o_blocking | i_host_tx_ready;
      o_host_tx_valid = i_tx_valid & ~o_blocking;
      o_host_tx_data  = i_tx_data;
      o_host_tx_last  = i_tx_last;
   end

   // Any logged error must stop host traffic on the next cycle
   a_block_after_err: assert property (@(posedge clk) disable iff (!rst_n)
      (|err_in && !i_clear_errors) |=> !o_host_tx_valid);

endmodule

//--- design/mmio_rsp_tracker.sv
`timescale 1ns/1ps

module mmio_rsp_tracker #(
   parameter int MMIO_DEPTH   = 4,
   parameter int MMIO_TIMEOUT = 64    // cycles
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  i_rx_hdr_vld,
   input  afu_chk_pkg::fmt_t     i_rx_fmt,
   input  afu_chk_pkg::tag_t     i_rx_tag,
   input  logic                  i_tx_hdr_vld,
   input  afu_chk_pkg::fmt_t     i_tx_fmt,
   input  afu_chk_pkg::tag_t     i_tx_tag,
   output afu_chk_pkg::err_vec_t o_err
);

   localparam int PTR_W = (MMIO_DEPTH > 1) ? $clog2(MMIO_DEPTH) : 1;
   localparam int CNT_W = $clog2(MMIO_DEPTH + 1);
   localparam int AGE_W = $clog2(MMIO_TIMEOUT + 1);

   afu_chk_pkg::tag_t tag_q [MMIO_DEPTH];   // Outstanding read tags, oldest at rd_ptr
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic [AGE_W-1:0]  age;
   logic              push;
   logic              cpl_seen;
   logic              cpl_match;
   logic              timeout_hit;
   logic              pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(MMIO_DEPTH - 1)) begin
         return '0;
      end else begin
         return ptr + 1'b1;
      end
   endfunction

   always_comb begin
      push        = i_rx_hdr_vld && (i_rx_fmt == afu_chk_pkg::FMT_MRD) &&
                    (count != CNT_W'(MMIO_DEPTH));   // Full queue drops the read
      cpl_seen    = i_tx_hdr_vld && (i_tx_fmt == afu_chk_pkg::FMT_CPLD);
      cpl_match   = cpl_seen && (count != '0) && (i_tx_tag == tag_q[rd_ptr]);
      timeout_hit = (count != '0) && (age == AGE_W'(MMIO_TIMEOUT - 1));
      pop         = cpl_match || timeout_hit;
   end

   always_ff @(posedge clk) begin
      if (push) tag_q[wr_ptr] <= i_rx_tag;
   end

   // ##############################
   // Queue pointers and age
   // ##############################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         age    <= '0;
         o_err  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Age restarts for each new head entry
         if (pop || count == '0) age <= '0;
         else                    age <= age + 1'b1;
         o_err <= '0;
         o_err[afu_chk_pkg::ERR_UNEXP_RSP]    <= cpl_seen && !cpl_match;
         o_err[afu_chk_pkg::ERR_MMIO_TIMEOUT] <= timeout_hit && !cpl_match;
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      count <= CNT_W'(MMIO_DEPTH));

endmodule

//--- design/tx_req_checker.sv
`timescale 1ns/1ps

module tx_req_checker #(
   parameter int MAX_PLD_SIZE    = 512,   // bytes
   parameter int MAX_RD_REQ_SIZE = 512,   // bytes
   parameter int MAX_TAGS        = 96
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  i_tx_hdr_vld,
   input  afu_chk_pkg::fmt_t     i_tx_fmt,
   input  afu_chk_pkg::len_dw_t  i_tx_len,
   input  afu_chk_pkg::tag_t     i_tx_tag,
   input  logic                  i_tx_beat_vld,
   input  logic                  i_tx_eop,
   output afu_chk_pkg::err_vec_t o_err
);

   localparam afu_chk_pkg::len_dw_t BEAT_DW = afu_chk_pkg::len_dw_t'(afu_chk_pkg::DW_PER_BEAT);

   logic                  is_mrd;
   logic                  is_mwr;
   logic                  is_cpld;
   logic [12:0]           len_bytes;
   logic [8:0]            exp_nxt;
   logic [8:0]            exp_beats;
   logic [8:0]            beat_cnt;
   logic [8:0]            cnt_inc;
   logic                  wr_active;
   logic                  ovr_seen;
   logic                  wr_short;
   logic                  wr_over;
   afu_chk_pkg::err_vec_t err_nxt;

   always_comb begin
      is_mrd    = (i_tx_fmt == afu_chk_pkg::FMT_MRD);
      is_mwr    = (i_tx_fmt == afu_chk_pkg::FMT_MWR);
      is_cpld   = (i_tx_fmt == afu_chk_pkg::FMT_CPLD);
      len_bytes = {i_tx_len, 2'b00};
      exp_nxt   = 9'((i_tx_len + BEAT_DW - 11'd1) / BEAT_DW);   // Round up to beats
      cnt_inc   = beat_cnt + 9'd1;
      wr_short  = 1'b0;
      wr_over   = 1'b0;
      if (i_tx_hdr_vld) begin
         wr_short = is_mwr & i_tx_eop;   // Write with no payload at all
      end else if (wr_active && i_tx_beat_vld) begin
         wr_over  = !ovr_seen && (cnt_inc > exp_beats);
         wr_short = i_tx_eop && (cnt_inc < exp_beats);
      end
   end

   // ##############################
   // Rule evaluation
   // ##############################
   always_comb begin
      err_nxt = '0;
      if (i_tx_hdr_vld) begin
         err_nxt[afu_chk_pkg::ERR_MALFORMED]  = !(is_mrd || is_mwr || is_cpld);
         err_nxt[afu_chk_pkg::ERR_MAX_PLD]    = is_mwr && (int'(len_bytes) > MAX_PLD_SIZE);
         err_nxt[afu_chk_pkg::ERR_MAX_RD_REQ] = is_mrd && (int'(len_bytes) > MAX_RD_REQ_SIZE);
         err_nxt[afu_chk_pkg::ERR_MAX_TAG]    = is_mrd && (int'(i_tx_tag) >= MAX_TAGS);
      end
      err_nxt[afu_chk_pkg::ERR_WR_INSUFF]  = wr_short;
      err_nxt[afu_chk_pkg::ERR_WR_OVERRUN] = wr_over;
   end

   // Write payload beat tracking
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_active <= 1'b0;
         beat_cnt  <= '0;
         ovr_seen  <= 1'b0;
         o_err     <= '0;
      end else begin
         o_err <= err_nxt;   // One-cycle pulses
         if (i_tx_hdr_vld) begin
            wr_active <= is_mwr & ~i_tx_eop;
            beat_cnt  <= '0;
            ovr_seen  <= 1'b0;
         end else if (wr_active && i_tx_beat_vld) begin
            if (!ovr_seen && !wr_over) beat_cnt <= cnt_inc;
            ovr_seen <= ovr_seen | wr_over;
            if (i_tx_eop) wr_active <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_tx_hdr_vld) exp_beats <= exp_nxt;
   end

endmodule

//--- design/tlp_field_capture.sv
`timescale 1ns/1ps

module tlp_field_capture (
   input  logic                  clk,
   input  logic                  rst_n,
   // Host to AFU stream
   input  logic                  i_rx_valid,
   input  logic                  i_rx_ready,
   input  afu_chk_pkg::data_t    i_rx_data,
   input  logic                  i_rx_last,
   // AFU to host stream
   input  logic                  i_tx_valid,
   input  logic                  i_tx_ready,
   input  afu_chk_pkg::data_t    i_tx_data,
   input  logic                  i_tx_last,
   output logic                  o_rx_hdr_vld,
   output afu_chk_pkg::fmt_t     o_rx_fmt,
   output afu_chk_pkg::tag_t     o_rx_tag,
   output logic                  o_tx_hdr_vld,
   output afu_chk_pkg::fmt_t     o_tx_fmt,
   output afu_chk_pkg::len_dw_t  o_tx_len,
   output afu_chk_pkg::tag_t     o_tx_tag,
   output afu_chk_pkg::hdr_t     o_tx_hdr,
   output logic                  o_tx_beat_vld,
   output logic                  o_tx_eop
);

   localparam afu_chk_pkg::len_dw_t LEN_MAX_DW = 11'd1024;

   logic              rx_hs;
   logic              rx_sop;
   logic              rx_in_pkt;
   logic              tx_hs;
   logic              tx_sop;
   logic              tx_in_pkt;
   afu_chk_pkg::hdr_t rx_hdr;
   afu_chk_pkg::hdr_t tx_hdr;

   always_comb begin
      rx_hs  = i_rx_valid & i_rx_ready;
      rx_sop = rx_hs & ~rx_in_pkt;     // First beat carries the header
      tx_hs  = i_tx_valid & i_tx_ready;
      tx_sop = tx_hs & ~tx_in_pkt;
      rx_hdr = i_rx_data[63:0];
      tx_hdr = i_tx_data[63:0];
   end

   // Packet framing and strobes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_in_pkt     <= 1'b0;
         tx_in_pkt     <= 1'b0;
         o_rx_hdr_vld  <= 1'b0;
         o_tx_hdr_vld  <= 1'b0;
         o_tx_beat_vld <= 1'b0;
         o_tx_eop      <= 1'b0;
      end else begin
         if (rx_hs) rx_in_pkt <= ~i_rx_last;
         if (tx_hs) tx_in_pkt <= ~i_tx_last;
         o_rx_hdr_vld  <= rx_sop;
         o_tx_hdr_vld  <= tx_sop;
         o_tx_beat_vld <= tx_hs & ~tx_sop;   // Payload beats only
         o_tx_eop      <= tx_hs & i_tx_last;
      end
   end

   // Decoded header fields
   always_ff @(posedge clk) begin
      if (rx_sop) begin
         o_rx_fmt <= rx_hdr[7:0];
         o_rx_tag <= rx_hdr[31:24];
      end
      if (tx_sop) begin
         o_tx_fmt <= tx_hdr[7:0];
         o_tx_len <= (tx_hdr[17:8] == 10'd0) ? LEN_MAX_DW : {1'b0, tx_hdr[17:8]};
         o_tx_tag <= tx_hdr[31:24];
         o_tx_hdr <= tx_hdr;
      end
   end

   // Source must hold a stalled beat
   a_rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (i_rx_valid && !i_rx_ready) |=> (i_rx_valid && $stable(i_rx_data)));
   a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)));

endmodule

//--- design/afu_chk_pkg.sv
package afu_chk_pkg;

   // ##############################
   // Stream and header widths
   // ##############################
   typedef logic [127:0] data_t;   // One stream beat
   typedef logic [63:0]  hdr_t;    // Header part of the first beat
   typedef logic [7:0]   fmt_t;
   typedef logic [10:0]  len_dw_t; // Holds 1024
   typedef logic [7:0]   tag_t;
   typedef logic [7:0]   err_vec_t;

   // Format type codes in header bits 7:0
   localparam fmt_t FMT_MRD  = 8'h00;
   localparam fmt_t FMT_MWR  = 8'h40;
   localparam fmt_t FMT_CPLD = 8'h4A;

   // ##############################
   // Error vector bit positions
   // ##############################
   localparam int ERR_MALFORMED    = 0;
   localparam int ERR_MAX_PLD      = 1;
   localparam int ERR_MAX_RD_REQ   = 2;
   localparam int ERR_MAX_TAG      = 3;
   localparam int ERR_WR_INSUFF    = 4;
   localparam int ERR_WR_OVERRUN   = 5;
   localparam int ERR_UNEXP_RSP    = 6;
   localparam int ERR_MMIO_TIMEOUT = 7;

   localparam int DW_PER_BEAT = 4;   // Payload dwords per beat

endpackage
